/* flist.f */
source/ws_pkg.sv
source/ws_pipe_reg.sv
source/ws_except_unit.sv
source/ws_csr_file.sv
source/ws_retire.sv
source/ws_top.sv
verif/ws_assert.sv
verif/ws_checker.sv
verif/ws_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the writeback stage testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module ws_tb -f flist.f \
    --Mdir obj_dir -o ws_sim \
    && ./obj_dir/ws_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log

grep -qx "TEST PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* source/ws_csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module ws_csr_file import ws_pkg::*; (
    input  wire        clk,
    input  wire        resetn,
    input  wire [13:0] ws_csr_num,
    input  wire [31:0] ws_csr_wmask,
    input  wire [31:0] ws_csr_wvalue,
    input  wire        csr_commit,
    input  wire        trap,
    input  wire        ertn_commit,
    input  wire [5:0]  ecode,
    input  wire [8:0]  esubcode,
    input  wire [1:0]  badv_sel,
    input  wire [31:0] ws_pc,
    input  wire [31:0] ws_vaddr,
    output logic [31:0] csr_rvalue,
    output logic [31:0] eentry,
    output logic [31:0] era
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] badv;
    logic [31:0] save0;

    // wvalue where the mask is set, old value elsewhere, only inside the writable field
    function automatic logic [31:0] masked_write(input logic [31:0] old,
                                                 input logic [31:0] field,
                                                 input logic [31:0] mask,
                                                 input logic [31:0] value);
        logic [31:0] sel;
        sel          = mask & field;
        masked_write = (old & ~sel) | (value & sel);
    endfunction

    always_comb begin
        case (ws_csr_num)
            CSR_CRMD:   csr_rvalue = crmd;
            CSR_PRMD:   csr_rvalue = prmd;
            CSR_ESTAT:  csr_rvalue = estat;
            CSR_ERA:    csr_rvalue = era;
            CSR_BADV:   csr_rvalue = badv;
            CSR_EENTRY: csr_rvalue = eentry;
            CSR_SAVE0:  csr_rvalue = save0;
            default:    csr_rvalue = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd   <= 32'h8;
            prmd   <= '0;
            estat  <= '0;
            era    <= '0;
            badv   <= '0;
            eentry <= '0;
            save0  <= '0;
        end else if (trap) begin
            // save the mode and drop to kernel level
            prmd[2:0]    <= crmd[2:0];
            crmd[2:0]    <= 3'b0;
            era          <= ws_pc;
            estat[21:16] <= ecode;
            estat[30:22] <= esubcode;
            if (badv_sel == BADV_PC) begin
                badv <= ws_pc;
            end else if (badv_sel == BADV_VA) begin
                badv <= ws_vaddr;
            end
        end else if (ertn_commit) begin
            crmd[2:0] <= prmd[2:0];
        end else if (csr_commit) begin
            case (ws_csr_num)
                CSR_CRMD: begin
                    crmd <= masked_write(crmd, 32'h0000_0007, ws_csr_wmask, ws_csr_wvalue);
                end
                CSR_PRMD: begin
                    prmd <= masked_write(prmd, 32'h0000_0007, ws_csr_wmask, ws_csr_wvalue);
                end
                CSR_ESTAT: begin
                    estat <= masked_write(estat, 32'h7fff_0000, ws_csr_wmask, ws_csr_wvalue);
                end
                CSR_ERA: begin
                    era <= masked_write(era, 32'hffff_ffff, ws_csr_wmask, ws_csr_wvalue);
                end
                CSR_BADV: begin
                    badv <= masked_write(badv, 32'hffff_ffff, ws_csr_wmask, ws_csr_wvalue);
                end
                CSR_EENTRY: begin
                    eentry <= masked_write(eentry, 32'hffff_ffc0, ws_csr_wmask, ws_csr_wvalue);
                end
                CSR_SAVE0: begin
                    save0 <= masked_write(save0, 32'hffff_ffff, ws_csr_wmask, ws_csr_wvalue);
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/ws_except_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ws_except_unit import ws_pkg::*; (
    input  wire             ws_valid,
    input  wire [EXC_W-1:0] ws_exc,
    input  wire             ws_ertn,
    output logic            exc_any,
    output logic            ertn,
    output logic [5:0]      ecode,
    output logic [8:0]      esubcode,
    output logic [1:0]      badv_sel
);

    assign exc_any = ws_valid & (|ws_exc);

    // an exception on the same instruction wins over its ertn
    assign ertn = ws_valid & ws_ertn & ~exc_any;

    // fixed priority, first match wins
    always_comb begin
        ecode    = ECODE_INT;
        esubcode = ESUB_ADEF;
        badv_sel = BADV_NONE;
        if (!exc_any) begin
            ecode = ECODE_INT;
        end else if (ws_exc[EXC_INT]) begin
            ecode = ECODE_INT;
        end else if (ws_exc[EXC_ADEF]) begin
            ecode    = ECODE_ADE;
            badv_sel = BADV_PC;
        end else if (ws_exc[EXC_TLBR_F]) begin
            ecode    = ECODE_TLBR;
            badv_sel = BADV_PC;
        end else if (ws_exc[EXC_PIF]) begin
            ecode    = ECODE_PIF;
            badv_sel = BADV_PC;
        end else if (ws_exc[EXC_PPI_F]) begin
            ecode    = ECODE_PPI;
            badv_sel = BADV_PC;
        end else if (ws_exc[EXC_INE]) begin
            ecode = ECODE_INE;
        end else if (ws_exc[EXC_SYS]) begin
            ecode = ECODE_SYS;
        end else if (ws_exc[EXC_BRK]) begin
            ecode = ECODE_BRK;
        end else if (ws_exc[EXC_ALE]) begin
            ecode    = ECODE_ALE;
            badv_sel = BADV_VA;
        end else if (ws_exc[EXC_ADEM]) begin
            // same ecode as adef, told apart by the subcode
            ecode    = ECODE_ADE;
            esubcode = ESUB_ADEM;
            badv_sel = BADV_VA;
        end else if (ws_exc[EXC_TLBR_M]) begin
            ecode    = ECODE_TLBR;
            badv_sel = BADV_VA;
        end else if (ws_exc[EXC_PIL]) begin
            ecode    = ECODE_PIL;
            badv_sel = BADV_VA;
        end else if (ws_exc[EXC_PIS]) begin
            ecode    = ECODE_PIS;
            badv_sel = BADV_VA;
        end else if (ws_exc[EXC_PME]) begin
            ecode    = ECODE_PME;
            badv_sel = BADV_VA;
        end else begin
            // only ppi on the memory side is left
            ecode    = ECODE_PPI;
            badv_sel = BADV_VA;
        end
    end

endmodule

`default_nettype wire

/* source/ws_pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ws_pipe_reg import ws_pkg::*; (
    input  wire              clk,
    input  wire              resetn,
    input  wire              flush,
    input  wire              ms_valid,
    input  wire [31:0]       ms_pc,
    input  wire [31:0]       ms_vaddr,
    input  wire              ms_rf_we,
    input  wire [4:0]        ms_rf_waddr,
    input  wire [31:0]       ms_rf_wdata,
    input  wire              ms_csr_re,
    input  wire              ms_csr_we,
    input  wire [13:0]       ms_csr_num,
    input  wire [31:0]       ms_csr_wmask,
    input  wire [31:0]       ms_csr_wvalue,
    input  wire              ms_ertn,
    input  wire [EXC_W-1:0]  ms_exc,
    output logic             ws_valid,
    output logic [31:0]      ws_pc,
    output logic [31:0]      ws_vaddr,
    output logic             ws_rf_we,
    output logic [4:0]       ws_rf_waddr,
    output logic [31:0]      ws_rf_wdata,
    output logic             ws_csr_re,
    output logic             ws_csr_we,
    output logic [13:0]      ws_csr_num,
    output logic [31:0]      ws_csr_wmask,
    output logic [31:0]      ws_csr_wvalue,
    output logic             ws_ertn,
    output logic [EXC_W-1:0] ws_exc
);

    logic accept;

    // stage is always ready, so only a flush blocks the incoming instruction
    assign accept = ms_valid & ~flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid      <= 1'b0;
            ws_pc         <= '0;
            ws_vaddr      <= '0;
            ws_rf_we      <= 1'b0;
            ws_rf_waddr   <= '0;
            ws_rf_wdata   <= '0;
            ws_csr_re     <= 1'b0;
            ws_csr_we     <= 1'b0;
            ws_csr_num    <= '0;
            ws_csr_wmask  <= '0;
            ws_csr_wvalue <= '0;
            ws_ertn       <= 1'b0;
            ws_exc        <= '0;
        end else begin
            ws_valid <= accept;
            if (accept) begin
                ws_pc         <= ms_pc;
                ws_vaddr      <= ms_vaddr;
                ws_rf_we      <= ms_rf_we;
                ws_rf_waddr   <= ms_rf_waddr;
                ws_rf_wdata   <= ms_rf_wdata;
                ws_csr_re     <= ms_csr_re;
                ws_csr_we     <= ms_csr_we;
                ws_csr_num    <= ms_csr_num;
                ws_csr_wmask  <= ms_csr_wmask;
                ws_csr_wvalue <= ms_csr_wvalue;
                ws_ertn       <= ms_ertn;
                ws_exc        <= ms_exc;
            end
        end
    end

endmodule

`default_nettype wire

/* source/ws_pkg.sv */
`default_nettype none

package ws_pkg;

    // width of the exception vector carried down the pipeline
    localparam int EXC_W = 15;

    // exception bit positions, highest priority first
    localparam int EXC_INT    = 0;
    localparam int EXC_ADEF   = 1;
    localparam int EXC_TLBR_F = 2;
    localparam int EXC_PIF    = 3;
    localparam int EXC_PPI_F  = 4;
    localparam int EXC_INE    = 5;
    localparam int EXC_SYS    = 6;
    localparam int EXC_BRK    = 7;
    localparam int EXC_ALE    = 8;
    localparam int EXC_ADEM   = 9;
    localparam int EXC_TLBR_M = 10;
    localparam int EXC_PIL    = 11;
    localparam int EXC_PIS    = 12;
    localparam int EXC_PME    = 13;
    localparam int EXC_PPI_M  = 14;

    // estat.ecode values
    localparam logic [5:0] ECODE_INT  = 6'h00;
    localparam logic [5:0] ECODE_PIL  = 6'h01;
    localparam logic [5:0] ECODE_PIS  = 6'h02;
    localparam logic [5:0] ECODE_PIF  = 6'h03;
    localparam logic [5:0] ECODE_PME  = 6'h04;
    localparam logic [5:0] ECODE_PPI  = 6'h07;
    localparam logic [5:0] ECODE_ADE  = 6'h08;
    localparam logic [5:0] ECODE_ALE  = 6'h09;
    localparam logic [5:0] ECODE_SYS  = 6'h0b;
    localparam logic [5:0] ECODE_BRK  = 6'h0c;
    localparam logic [5:0] ECODE_INE  = 6'h0d;
    localparam logic [5:0] ECODE_TLBR = 6'h3f;

    // estat.esubcode values for address errors
    localparam logic [8:0] ESUB_ADEF = 9'd0;
    localparam logic [8:0] ESUB_ADEM = 9'd1;

    // csr numbers
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;

    // source of the bad virtual address on a trap
    localparam logic [1:0] BADV_NONE = 2'd0;
    localparam logic [1:0] BADV_PC   = 2'd1;
    localparam logic [1:0] BADV_VA   = 2'd2;

endpackage

`default_nettype wire

/* source/ws_retire.sv */
`timescale 1ns/1ps
`default_nettype none

module ws_retire (
    input  wire         ws_valid,
    input  wire  [31:0] ws_pc,
    input  wire         ws_rf_we,
    input  wire  [4:0]  ws_rf_waddr,
    input  wire  [31:0] ws_rf_wdata,
    input  wire         ws_csr_re,
    input  wire         ws_csr_we,
    input  wire         exc_any,
    input  wire         ertn,
    input  wire  [31:0] csr_rvalue,
    input  wire  [31:0] eentry,
    input  wire  [31:0] era,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata,
    output logic        csr_commit,
    output logic        trap,
    output logic        ertn_commit,
    output logic        flush,
    output logic [31:0] flush_target
);

    logic commit;

    // a trapping instruction or an ertn writes nothing back
    assign commit = ws_valid & ~exc_any & ~ertn;

    assign rf_we    = commit & ws_rf_we;
    assign rf_waddr = ws_rf_waddr;
    assign rf_wdata = ws_csr_re ? csr_rvalue : ws_rf_wdata;

    assign csr_commit  = commit & ws_csr_we;
    assign trap        = exc_any;
    assign ertn_commit = ertn;

    assign flush        = exc_any | ertn;
    assign flush_target = exc_any ? eentry : era;

    // trace port follows the register commit
    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

/* source/ws_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ws_top import ws_pkg::*; (
    input  wire              clk,
    input  wire              resetn,
    input  wire              ms_valid,
    input  wire [31:0]       ms_pc,
    input  wire [31:0]       ms_vaddr,
    input  wire              ms_rf_we,
    input  wire [4:0]        ms_rf_waddr,
    input  wire [31:0]       ms_rf_wdata,
    input  wire              ms_csr_re,
    input  wire              ms_csr_we,
    input  wire [13:0]       ms_csr_num,
    input  wire [31:0]       ms_csr_wmask,
    input  wire [31:0]       ms_csr_wvalue,
    input  wire              ms_ertn,
    input  wire [EXC_W-1:0]  ms_exc,
    output logic             rf_we,
    output logic [4:0]       rf_waddr,
    output logic [31:0]      rf_wdata,
    output logic [31:0]      debug_wb_pc,
    output logic [3:0]       debug_wb_rf_we,
    output logic [4:0]       debug_wb_rf_wnum,
    output logic [31:0]      debug_wb_rf_wdata,
    output logic             wb_ex,
    output logic [5:0]       wb_ecode,
    output logic             flush,
    output logic [31:0]      flush_target
);

    logic             ws_valid;
    logic [31:0]      ws_pc;
    logic [31:0]      ws_vaddr;
    logic             ws_rf_we;
    logic [4:0]       ws_rf_waddr;
    logic [31:0]      ws_rf_wdata;
    logic             ws_csr_re;
    logic             ws_csr_we;
    logic [13:0]      ws_csr_num;
    logic [31:0]      ws_csr_wmask;
    logic [31:0]      ws_csr_wvalue;
    logic             ws_ertn;
    logic [EXC_W-1:0] ws_exc;

    logic             exc_any;
    logic             ertn;
    logic [5:0]       ecode;
    logic [8:0]       esubcode;
    logic [1:0]       badv_sel;

    logic [31:0]      csr_rvalue;
    logic [31:0]      eentry;
    logic [31:0]      era;

    logic             csr_commit;
    logic             trap;
    logic             ertn_commit;

    ws_pipe_reg u_pipe_reg (
        .clk           (clk),
        .resetn        (resetn),
        .flush         (flush),
        .ms_valid      (ms_valid),
        .ms_pc         (ms_pc),
        .ms_vaddr      (ms_vaddr),
        .ms_rf_we      (ms_rf_we),
        .ms_rf_waddr   (ms_rf_waddr),
        .ms_rf_wdata   (ms_rf_wdata),
        .ms_csr_re     (ms_csr_re),
        .ms_csr_we     (ms_csr_we),
        .ms_csr_num    (ms_csr_num),
        .ms_csr_wmask  (ms_csr_wmask),
        .ms_csr_wvalue (ms_csr_wvalue),
        .ms_ertn       (ms_ertn),
        .ms_exc        (ms_exc),
        .ws_valid      (ws_valid),
        .ws_pc         (ws_pc),
        .ws_vaddr      (ws_vaddr),
        .ws_rf_we      (ws_rf_we),
        .ws_rf_waddr   (ws_rf_waddr),
        .ws_rf_wdata   (ws_rf_wdata),
        .ws_csr_re     (ws_csr_re),
        .ws_csr_we     (ws_csr_we),
        .ws_csr_num    (ws_csr_num),
        .ws_csr_wmask  (ws_csr_wmask),
        .ws_csr_wvalue (ws_csr_wvalue),
        .ws_ertn       (ws_ertn),
        .ws_exc        (ws_exc)
    );

    ws_except_unit u_except (
        .ws_valid (ws_valid),
        .ws_exc   (ws_exc),
        .ws_ertn  (ws_ertn),
        .exc_any  (exc_any),
        .ertn     (ertn),
        .ecode    (ecode),
        .esubcode (esubcode),
        .badv_sel (badv_sel)
    );

    ws_csr_file u_csr (
        .clk           (clk),
        .resetn        (resetn),
        .ws_csr_num    (ws_csr_num),
        .ws_csr_wmask  (ws_csr_wmask),
        .ws_csr_wvalue (ws_csr_wvalue),
        .csr_commit    (csr_commit),
        .trap          (trap),
        .ertn_commit   (ertn_commit),
        .ecode         (ecode),
        .esubcode      (esubcode),
        .badv_sel      (badv_sel),
        .ws_pc         (ws_pc),
        .ws_vaddr      (ws_vaddr),
        .csr_rvalue    (csr_rvalue),
        .eentry        (eentry),
        .era           (era)
    );

    ws_retire u_retire (
        .ws_valid          (ws_valid),
        .ws_pc             (ws_pc),
        .ws_rf_we          (ws_rf_we),
        .ws_rf_waddr       (ws_rf_waddr),
        .ws_rf_wdata       (ws_rf_wdata),
        .ws_csr_re         (ws_csr_re),
        .ws_csr_we         (ws_csr_we),
        .exc_any           (exc_any),
        .ertn              (ertn),
        .csr_rvalue        (csr_rvalue),
        .eentry            (eentry),
        .era               (era),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .csr_commit        (csr_commit),
        .trap              (trap),
        .ertn_commit       (ertn_commit),
        .flush             (flush),
        .flush_target      (flush_target)
    );

    assign wb_ex    = exc_any;
    assign wb_ecode = ecode;

endmodule

`default_nettype wire

/* verif/ws_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module ws_assert (
    input wire       clk,
    input wire       resetn,
    input wire       rf_we,
    input wire [3:0] debug_wb_rf_we,
    input wire       wb_ex,
    input wire       ertn,
    input wire       flush
);

    // a flush has exactly one cause, a trap or an ertn
    flush_one_cause: assert property (@(posedge clk) disable iff (!resetn)
        flush |-> (wb_ex != ertn))
        else $error("flush raised without exactly one of trap and ertn");

    // trap or ertn, never a register write alongside
    flush_no_write: assert property (@(posedge clk) disable iff (!resetn) flush |-> !rf_we)
        else $error("rf_we high together with flush");

    flush_no_trace: assert property (@(posedge clk) disable iff (!resetn)
        flush |-> (debug_wb_rf_we == 4'b0))
        else $error("trace write enable high together with flush");

    // synchronous reset, so outputs go quiet one edge later
    reset_quiet: assert property (@(posedge clk)
        !resetn |=> (!rf_we && debug_wb_rf_we == 4'b0 && !wb_ex && !flush))
        else $error("outputs active during reset");

endmodule

bind ws_top ws_assert u_assert (.*);

`default_nettype wire

/* verif/ws_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ws_checker import ws_pkg::*; (
    input wire             clk,
    input wire             resetn,
    input wire             ms_valid,
    input wire [31:0]      ms_pc,
    input wire [31:0]      ms_vaddr,
    input wire             ms_rf_we,
    input wire [4:0]       ms_rf_waddr,
    input wire [31:0]      ms_rf_wdata,
    input wire             ms_csr_re,
    input wire             ms_csr_we,
    input wire [13:0]      ms_csr_num,
    input wire [31:0]      ms_csr_wmask,
    input wire [31:0]      ms_csr_wvalue,
    input wire             ms_ertn,
    input wire [EXC_W-1:0] ms_exc,
    input wire             rf_we,
    input wire [4:0]       rf_waddr,
    input wire [31:0]      rf_wdata,
    input wire [31:0]      debug_wb_pc,
    input wire [3:0]       debug_wb_rf_we,
    input wire [4:0]       debug_wb_rf_wnum,
    input wire [31:0]      debug_wb_rf_wdata,
    input wire             wb_ex,
    input wire [5:0]       wb_ecode,
    input wire             flush,
    input wire [31:0]      flush_target
);

    int error_count = 0;
    int check_count = 0;
    int trap_count  = 0;
    int ertn_count  = 0;
    int drop_count  = 0;

    // stage register model
    logic             m_valid;
    logic [31:0]      m_pc;
    logic [31:0]      m_vaddr;
    logic             m_rf_we;
    logic [4:0]       m_rf_waddr;
    logic [31:0]      m_rf_wdata;
    logic             m_csr_re;
    logic             m_csr_we;
    logic [13:0]      m_csr_num;
    logic [31:0]      m_wmask;
    logic [31:0]      m_wvalue;
    logic             m_ertn;
    logic [EXC_W-1:0] m_exc;

    // csr model
    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] badv;
    logic [31:0] eentry;
    logic [31:0] save0;

    function automatic logic [5:0] ecode_of_bit(input int b);
        case (b)
            EXC_INT:    ecode_of_bit = ECODE_INT;
            EXC_ADEF:   ecode_of_bit = ECODE_ADE;
            EXC_TLBR_F: ecode_of_bit = ECODE_TLBR;
            EXC_PIF:    ecode_of_bit = ECODE_PIF;
            EXC_PPI_F:  ecode_of_bit = ECODE_PPI;
            EXC_INE:    ecode_of_bit = ECODE_INE;
            EXC_SYS:    ecode_of_bit = ECODE_SYS;
            EXC_BRK:    ecode_of_bit = ECODE_BRK;
            EXC_ALE:    ecode_of_bit = ECODE_ALE;
            EXC_ADEM:   ecode_of_bit = ECODE_ADE;
            EXC_TLBR_M: ecode_of_bit = ECODE_TLBR;
            EXC_PIL:    ecode_of_bit = ECODE_PIL;
            EXC_PIS:    ecode_of_bit = ECODE_PIS;
            EXC_PME:    ecode_of_bit = ECODE_PME;
            default:    ecode_of_bit = ECODE_PPI;
        endcase
    endfunction

    function automatic logic [31:0] csr_read(input logic [13:0] num);
        case (num)
            CSR_CRMD:   csr_read = crmd;
            CSR_PRMD:   csr_read = prmd;
            CSR_ESTAT:  csr_read = estat;
            CSR_ERA:    csr_read = era;
            CSR_BADV:   csr_read = badv;
            CSR_EENTRY: csr_read = eentry;
            CSR_SAVE0:  csr_read = save0;
            default:    csr_read = 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] writable_bits(input logic [13:0] num);
        case (num)
            CSR_CRMD:   writable_bits = 32'h0000_0007;
            CSR_PRMD:   writable_bits = 32'h0000_0007;
            CSR_ESTAT:  writable_bits = 32'h7fff_0000;
            CSR_EENTRY: writable_bits = 32'hffff_ffc0;
            CSR_ERA:    writable_bits = 32'hffff_ffff;
            CSR_BADV:   writable_bits = 32'hffff_ffff;
            CSR_SAVE0:  writable_bits = 32'hffff_ffff;
            default:    writable_bits = 32'h0;
        endcase
    endfunction

    task automatic csr_store(input logic [13:0] num, input logic [31:0] value);
        case (num)
            CSR_CRMD:   crmd = value;
            CSR_PRMD:   prmd = value;
            CSR_ESTAT:  estat = value;
            CSR_ERA:    era = value;
            CSR_BADV:   badv = value;
            CSR_EENTRY: eentry = value;
            CSR_SAVE0:  save0 = value;
            default:    ;
        endcase
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic reset_model();
        m_valid    = 1'b0;
        m_pc       = '0;
        m_vaddr    = '0;
        m_rf_we    = 1'b0;
        m_rf_waddr = '0;
        m_rf_wdata = '0;
        m_csr_re   = 1'b0;
        m_csr_we   = 1'b0;
        m_csr_num  = '0;
        m_wmask    = '0;
        m_wvalue   = '0;
        m_ertn     = 1'b0;
        m_exc      = '0;
        crmd       = 32'h8;
        prmd       = '0;
        estat      = '0;
        era        = '0;
        badv       = '0;
        eentry     = '0;
        save0      = '0;
    endtask

    // outputs are stable at the falling edge, and so are the inputs
    // that the next rising edge will take
    always @(negedge clk) begin : model_step
        logic        e_exc;
        logic        e_ertn;
        logic        e_commit;
        logic        e_rf_we;
        logic        e_flush;
        logic        found;
        logic [5:0]  e_ecode;
        logic [8:0]  e_esub;
        logic [1:0]  e_badv;
        logic [31:0] e_wdata;
        logic [31:0] mask;
        if (!resetn) begin
            reset_model();
        end else begin
            e_exc    = m_valid & (|m_exc);
            e_ertn   = m_valid & m_ertn & ~e_exc;
            e_commit = m_valid & ~e_exc & ~e_ertn;
            e_rf_we  = e_commit & m_rf_we;
            e_flush  = e_exc | e_ertn;
            e_wdata  = m_csr_re ? csr_read(m_csr_num) : m_rf_wdata;
            found    = 1'b0;
            e_ecode  = ECODE_INT;
            e_esub   = ESUB_ADEF;
            e_badv   = BADV_NONE;
            // bit index is the priority, lowest index wins
            for (int i = 0; i < EXC_W; i++) begin
                if (m_exc[4'(i)] && !found) begin
                    found   = 1'b1;
                    e_ecode = ecode_of_bit(i);
                    e_esub  = (i == EXC_ADEM) ? ESUB_ADEM : ESUB_ADEF;
                    if (i >= EXC_ADEF && i <= EXC_PPI_F) begin
                        e_badv = BADV_PC;
                    end else if (i >= EXC_ALE) begin
                        e_badv = BADV_VA;
                    end
                end
            end

            compare_value("rf_we", 32'(rf_we), 32'(e_rf_we));
            compare_value("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'({4{e_rf_we}}));
            if (e_rf_we) begin
                compare_value("rf_waddr", 32'(rf_waddr), 32'(m_rf_waddr));
                compare_value("rf_wdata", rf_wdata, e_wdata);
                compare_value("debug_wb_pc", debug_wb_pc, m_pc);
                compare_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(m_rf_waddr));
                compare_value("debug_wb_rf_wdata", debug_wb_rf_wdata, e_wdata);
            end
            compare_value("wb_ex", 32'(wb_ex), 32'(e_exc));
            compare_value("flush", 32'(flush), 32'(e_flush));
            if (e_exc) begin
                compare_value("wb_ecode", 32'(wb_ecode), 32'(e_ecode));
            end
            if (e_flush) begin
                compare_value("flush_target", flush_target, e_exc ? eentry : era);
            end

            // csr effects land at the coming edge
            if (e_exc) begin
                trap_count++;
                prmd[2:0]    = crmd[2:0];
                crmd[2:0]    = 3'b0;
                era          = m_pc;
                estat[21:16] = e_ecode;
                estat[30:22] = e_esub;
                if (e_badv == BADV_PC) begin
                    badv = m_pc;
                end else if (e_badv == BADV_VA) begin
                    badv = m_vaddr;
                end
            end else if (e_ertn) begin
                ertn_count++;
                crmd[2:0] = prmd[2:0];
            end else if (e_commit && m_csr_we) begin
                mask = m_wmask & writable_bits(m_csr_num);
                csr_store(m_csr_num, (csr_read(m_csr_num) & ~mask) | (m_wvalue & mask));
            end

            // a flush kills whatever arrives with it
            if (ms_valid && e_flush) begin
                drop_count++;
            end
            m_valid = ms_valid & ~e_flush;
            if (m_valid) begin
                m_pc       = ms_pc;
                m_vaddr    = ms_vaddr;
                m_rf_we    = ms_rf_we;
                m_rf_waddr = ms_rf_waddr;
                m_rf_wdata = ms_rf_wdata;
                m_csr_re   = ms_csr_re;
                m_csr_we   = ms_csr_we;
                m_csr_num  = ms_csr_num;
                m_wmask    = ms_csr_wmask;
                m_wvalue   = ms_csr_wvalue;
                m_ertn     = ms_ertn;
                m_exc      = ms_exc;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/ws_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ws_tb import ws_pkg::*; ();

    logic             clk;
    logic             resetn;
    logic             ms_valid;
    logic [31:0]      ms_pc;
    logic [31:0]      ms_vaddr;
    logic             ms_rf_we;
    logic [4:0]       ms_rf_waddr;
    logic [31:0]      ms_rf_wdata;
    logic             ms_csr_re;
    logic             ms_csr_we;
    logic [13:0]      ms_csr_num;
    logic [31:0]      ms_csr_wmask;
    logic [31:0]      ms_csr_wvalue;
    logic             ms_ertn;
    logic [EXC_W-1:0] ms_exc;

    wire              rf_we;
    wire  [4:0]       rf_waddr;
    wire  [31:0]      rf_wdata;
    wire  [31:0]      debug_wb_pc;
    wire  [3:0]       debug_wb_rf_we;
    wire  [4:0]       debug_wb_rf_wnum;
    wire  [31:0]      debug_wb_rf_wdata;
    wire              wb_ex;
    wire  [5:0]       wb_ecode;
    wire              flush;
    wire  [31:0]      flush_target;

    int               timeout_count;
    int               coverage_gaps;
    logic [13:0]      csr_pick [8];

    ws_top dut (.*);

    ws_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic drive_idle();
        ms_valid      = 1'b0;
        ms_pc         = '0;
        ms_vaddr      = '0;
        ms_rf_we      = 1'b0;
        ms_rf_waddr   = '0;
        ms_rf_wdata   = '0;
        ms_csr_re     = 1'b0;
        ms_csr_we     = 1'b0;
        ms_csr_num    = '0;
        ms_csr_wmask  = '0;
        ms_csr_wvalue = '0;
        ms_ertn       = 1'b0;
        ms_exc        = '0;
    endtask

    task automatic drive_random();
        logic [3:0] bit_a;
        logic [3:0] bit_b;
        logic [2:0] pick;
        bit_a         = 4'($urandom_range(EXC_W - 1, 0));
        bit_b         = 4'($urandom_range(EXC_W - 1, 0));
        pick          = 3'($urandom_range(7, 0));
        ms_valid      = ($urandom_range(99, 0) < 80);
        ms_pc         = $urandom;
        ms_vaddr      = $urandom;
        ms_rf_we      = 1'($urandom);
        ms_rf_waddr   = 5'($urandom);
        ms_rf_wdata   = $urandom;
        ms_csr_re     = ($urandom_range(99, 0) < 40);
        ms_csr_we     = ($urandom_range(99, 0) < 40);
        ms_csr_num    = csr_pick[pick];
        // full mask now and then, so whole fields get rewritten
        ms_csr_wmask  = ($urandom_range(3, 0) == 0) ? 32'hffff_ffff : $urandom;
        ms_csr_wvalue = $urandom;
        ms_ertn       = ($urandom_range(99, 0) < 5);
        ms_exc        = '0;
        if ($urandom_range(99, 0) >= 75) begin
            ms_exc[bit_a] = 1'b1;
            if ($urandom_range(1, 0) == 1) begin
                ms_exc[bit_b] = 1'b1;
            end
        end
    endtask

    // stage is empty once the model holds nothing and no flush is pending
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((u_checker.m_valid || flush === 1'b1) && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (u_checker.m_valid || flush === 1'b1) begin
            timeout_count++;
            $display("timeout: the stage did not drain within 100 cycles");
        end
    endtask

    initial begin
        int n;
        void'($urandom(88745));
        timeout_count = 0;
        coverage_gaps = 0;
        csr_pick[0]   = CSR_CRMD;
        csr_pick[1]   = CSR_PRMD;
        csr_pick[2]   = CSR_ESTAT;
        csr_pick[3]   = CSR_ERA;
        csr_pick[4]   = CSR_BADV;
        csr_pick[5]   = CSR_EENTRY;
        csr_pick[6]   = CSR_SAVE0;
        // not implemented, reads as zero
        csr_pick[7]   = 14'h0ab;
        resetn        = 1'b0;
        drive_idle();
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        for (n = 0; n < 3000; n++) begin
            @(posedge clk);
            #1;
            drive_random();
        end
        @(posedge clk);
        #1;
        drive_idle();
        wait_drain();
        repeat (2) @(posedge clk);
        if (u_checker.trap_count == 0) begin
            coverage_gaps++;
            $display("no trap was retired during the run");
        end
        if (u_checker.ertn_count == 0) begin
            coverage_gaps++;
            $display("no ertn was retired during the run");
        end
        if (u_checker.drop_count == 0) begin
            coverage_gaps++;
            $display("no instruction arrived in a flush cycle");
        end
        $display("errors: mismatches=%0d timeouts=%0d coverage=%0d checks=%0d",
                 u_checker.error_count, timeout_count, coverage_gaps,
                 u_checker.check_count);
        if (u_checker.error_count == 0 && timeout_count == 0 && coverage_gaps == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
